/* design/obi_integrity_config.svh */
// Bus, checksum and fault code parameters shared by the integrity unit
// Both buses use the same address and data widths
// OBI_MAX_OUTSTANDING must be at least 1

`ifndef OBI_INTEGRITY_CONFIG_SVH
`define OBI_INTEGRITY_CONFIG_SVH

`define OBI_ADDR_W 32
`define OBI_DATA_W 32

// Request and response checksum widths
`define ACHK_W 13
`define RCHK_W 5

// Only this rchk bit is meaningful for a store response
`define RCHK_STORE_BIT 4

`define OBI_MAX_OUTSTANDING 2

`define FAULT_CODE_W 11
`define FAULT_LOAD_INTEGRITY 11'h402
`define FAULT_STORE_INTEGRITY 11'h403

`endif

/* design/obi_integrity_pkg.sv */
// Types and checksum functions for the OBI integrity unit
// The checksums assume 32-bit address and data with byte-wise parity
// atop, mid and exokay are not carried and enter the checksums as zero

`include "obi_integrity_config.svh"

package obi_integrity_pkg;

  typedef struct packed {
    logic [`OBI_ADDR_W-1:0]   addr;
    logic                     we;
    logic [`OBI_DATA_W/8-1:0] be;
    logic [`OBI_DATA_W-1:0]   wdata;
    logic [2:0]               prot;
    logic [1:0]               memtype;
    logic                     dbg;
  } obi_req_t;

  typedef struct packed {
    logic                 req;
    logic                 reqpar;
    obi_req_t             payload;
    logic [`ACHK_W-1:0]   achk;
  } obi_bus_out_t;

  typedef struct packed {
    logic [`OBI_DATA_W-1:0] rdata;
    logic                   err;
    logic [`RCHK_W-1:0]     rchk;
  } obi_resp_t;

  // Field order keeps instr_tag_t equal to the low bits of data_tag_t
  typedef struct packed {
    logic had_integrity;
    logic gnt_par_fault;
  } instr_tag_t;

  typedef struct packed {
    logic is_store;
    logic had_integrity;
    logic gnt_par_fault;
  } data_tag_t;

  typedef struct packed {
    logic      valid;
    obi_resp_t resp;
    logic      rvalid_par_fault;
    logic      is_store;
    logic      had_integrity;
    logic      gnt_par_fault;
  } resp_event_t;

  // Bits 7 and 6 cover atop and mid, which are always zero
  function automatic logic [`ACHK_W-1:0] f_achk(input obi_req_t req);
    f_achk = {^req.wdata[31:24], ^req.wdata[23:16], ^req.wdata[15:8], ^req.wdata[7:0],
              ~req.dbg, 1'b0, 1'b0, ~^{req.be, req.we}, ~^{req.prot, req.memtype},
              ^req.addr[31:24], ^req.addr[23:16], ^req.addr[15:8], ^req.addr[7:0]};
  endfunction

  // exokay is always zero, so bit 4 reduces to err
  function automatic logic [`RCHK_W-1:0] f_rchk(input logic err,
                                                input logic [`OBI_DATA_W-1:0] rdata);
    f_rchk = {^{err, 1'b0}, ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

endpackage

/* design/obi_outstanding_fifo.sv */
// Tag FIFO for requests granted but not yet answered
// Pushes while full and pops while empty are dropped
// head_tag is undefined while the FIFO is empty

`timescale 1ns/1ns
`include "obi_integrity_config.svh"

module obi_outstanding_fifo
  import obi_integrity_pkg::*;
#(
  parameter type tag_t = instr_tag_t
) (
  input  logic clk_i,
  input  logic arst_n,
  input  logic push,
  input  tag_t push_tag,
  input  logic pop,
  output tag_t head_tag,
  output logic full
);

  localparam int DEPTH = `OBI_MAX_OUTSTANDING;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  tag_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full     = (count == CNT_W'(DEPTH));
  assign do_push  = push && !full;
  assign do_pop   = pop && (count != '0);
  assign head_tag = mem[rd_ptr];

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_tag;
    end
  end

endmodule

/* design/obi_bus_port.sv */
// Request side and strobe checks for one OBI bus
// tag_t is instr_tag_t or data_tag_t; a narrower tag keeps the low fields
// Responses must arrive in request order, one per granted request
// The core must hold its request until req_ready and gnt are both high

`timescale 1ns/1ns

module obi_bus_port
  import obi_integrity_pkg::*;
#(
  parameter type tag_t = instr_tag_t
) (
  input  logic         clk_i,
  input  logic         arst_n,
  input  logic         integrity_en,
  input  logic         core_valid,
  input  obi_req_t     core_req,
  output logic         req_ready,
  output obi_bus_out_t bus_out,
  input  logic         gnt,
  input  logic         gntpar,
  input  logic         rvalid,
  input  logic         rvalidpar,
  input  obi_resp_t    resp,
  output resp_event_t  resp_evt,
  output logic         parity_fault
);

  logic      fifo_full;
  logic      bus_req;
  logic      granted;
  logic      gnt_par_fault;
  logic      rvalid_par_fault;
  data_tag_t push_full;
  data_tag_t head_full;
  tag_t      push_tag;
  tag_t      head_tag;

  // No new request once every outstanding slot is taken
  assign req_ready = !fifo_full;
  assign bus_req   = core_valid && !fifo_full;
  assign granted   = bus_req && gnt;

  always_comb begin
    bus_out.req     = bus_req;
    bus_out.reqpar  = ~bus_req;
    bus_out.payload = core_req;
    bus_out.achk    = f_achk(core_req);
  end

  // Parity strobes must always be the inverse of their strobe
  assign gnt_par_fault    = (gntpar == gnt);
  assign rvalid_par_fault = (rvalidpar == rvalid);
  assign parity_fault     = gnt_par_fault || rvalid_par_fault;

  always_comb begin
    push_full.is_store      = core_req.we;
    push_full.had_integrity = integrity_en;
    push_full.gnt_par_fault = gnt_par_fault;
    push_tag                = tag_t'(push_full[$bits(tag_t)-1:0]);
  end

  obi_outstanding_fifo #(
    .tag_t (tag_t)
  ) i_fifo (
    .clk_i    (clk_i),
    .arst_n   (arst_n),
    .push     (granted),
    .push_tag (push_tag),
    .pop      (rvalid),
    .head_tag (head_tag),
    .full     (fifo_full)
  );

  // Fields missing from a narrow tag read back as zero
  always_comb begin
    head_full                        = '0;
    head_full[$bits(tag_t)-1:0]      = head_tag;
    resp_evt.valid                   = rvalid;
    resp_evt.resp                    = resp;
    resp_evt.rvalid_par_fault        = rvalid_par_fault;
    resp_evt.is_store                = head_full.is_store;
    resp_evt.had_integrity           = head_full.had_integrity;
    resp_evt.gnt_par_fault           = head_full.gnt_par_fault;
  end

endmodule

/* design/obi_rchk_checker.sv */
// Response checksum check for one bus
// Stores are checked on the err bit of rchk only
// The error output is a one-cycle pulse after the response

`timescale 1ns/1ns
`include "obi_integrity_config.svh"

module obi_rchk_checker
  import obi_integrity_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n,
  input  logic        integrity_en,
  input  resp_event_t resp_evt,
  output logic        integrity_err,
  output logic        err_is_store
);

  logic [`RCHK_W-1:0] rchk_calc;
  logic               rchk_mismatch;
  logic               chk_fault;
  logic               err_next;

  assign rchk_calc = f_rchk(resp_evt.resp.err, resp_evt.resp.rdata);

  assign rchk_mismatch = resp_evt.is_store ?
      (resp_evt.resp.rchk[`RCHK_STORE_BIT] != rchk_calc[`RCHK_STORE_BIT]) :
      (resp_evt.resp.rchk != rchk_calc);

  // Checksum faults count only for requests sent with integrity
  assign chk_fault = integrity_en && resp_evt.had_integrity && rchk_mismatch;

  assign err_next = resp_evt.valid &&
      (chk_fault || resp_evt.rvalid_par_fault || resp_evt.gnt_par_fault);

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      integrity_err <= 1'b0;
      err_is_store  <= 1'b0;
    end else begin
      integrity_err <= err_next;
      err_is_store  <= resp_evt.valid && resp_evt.is_store;
    end
  end

endmodule

/* design/integrity_alert_unit.sv */
// Major alert and data fault code for both buses
// The alert and the fault code hold until reset
// Only the first data integrity error sets the fault code

`timescale 1ns/1ns
`include "obi_integrity_config.svh"

module integrity_alert_unit
  import obi_integrity_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n,
  input  logic                     instr_parity_fault,
  input  logic                     data_parity_fault,
  input  logic                     instr_err,
  input  logic                     data_err,
  input  logic                     data_err_is_store,
  output logic                     alert_major,
  output logic [`FAULT_CODE_W-1:0] fault_code
);

  logic any_fault;
  logic code_free;

  assign any_fault = instr_parity_fault || data_parity_fault || instr_err || data_err;

  // Both fault codes are nonzero, so zero marks an empty code register
  assign code_free = (fault_code == '0);

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      alert_major <= 1'b0;
    end else if (any_fault) begin
      alert_major <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      fault_code <= '0;
    end else if (data_err && code_free) begin
      fault_code <= data_err_is_store ? `FAULT_STORE_INTEGRITY : `FAULT_LOAD_INTEGRITY;
    end
  end

endmodule

/* design/obi_integrity_unit.sv */
// Integrity unit for the instruction fetch and data OBI buses
// The fetch bus always sends be all ones, we low and wdata zero
// integrity_en is sampled per request and also gates the rchk check

`timescale 1ns/1ns
`include "obi_integrity_config.svh"

module obi_integrity_unit
  import obi_integrity_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n,
  input  logic                     integrity_en,
  input  logic                     instr_valid,
  input  obi_req_t                 instr_req,
  output logic                     instr_ready,
  output obi_bus_out_t             instr_bus,
  input  logic                     instr_gnt,
  input  logic                     instr_gntpar,
  input  logic                     instr_rvalid,
  input  logic                     instr_rvalidpar,
  input  obi_resp_t                instr_resp,
  input  logic                     data_valid,
  input  obi_req_t                 data_req,
  output logic                     data_ready,
  output obi_bus_out_t             data_bus,
  input  logic                     data_gnt,
  input  logic                     data_gntpar,
  input  logic                     data_rvalid,
  input  logic                     data_rvalidpar,
  input  obi_resp_t                data_resp,
  output logic                     instr_integrity_err,
  output logic                     data_integrity_err,
  output logic                     alert_major,
  output logic [`FAULT_CODE_W-1:0] fault_code
);

  obi_req_t    instr_req_fixed;
  resp_event_t instr_evt;
  resp_event_t data_evt;
  logic        instr_parity_fault;
  logic        data_parity_fault;
  logic        data_err_is_store;

  // Fetches are word reads, whatever the core puts in these fields
  always_comb begin
    instr_req_fixed       = instr_req;
    instr_req_fixed.be    = '1;
    instr_req_fixed.we    = 1'b0;
    instr_req_fixed.wdata = '0;
  end

  obi_bus_port #(.tag_t(instr_tag_t)) i_instr_port (
    .clk_i(clk_i), .arst_n(arst_n), .integrity_en(integrity_en),
    .core_valid(instr_valid), .core_req(instr_req_fixed), .req_ready(instr_ready),
    .bus_out(instr_bus), .gnt(instr_gnt), .gntpar(instr_gntpar),
    .rvalid(instr_rvalid), .rvalidpar(instr_rvalidpar), .resp(instr_resp),
    .resp_evt(instr_evt), .parity_fault(instr_parity_fault)
  );

  obi_bus_port #(.tag_t(data_tag_t)) i_data_port (
    .clk_i(clk_i), .arst_n(arst_n), .integrity_en(integrity_en),
    .core_valid(data_valid), .core_req(data_req), .req_ready(data_ready),
    .bus_out(data_bus), .gnt(data_gnt), .gntpar(data_gntpar),
    .rvalid(data_rvalid), .rvalidpar(data_rvalidpar), .resp(data_resp),
    .resp_evt(data_evt), .parity_fault(data_parity_fault)
  );

  // A fetch never stores, so its store flag stays open
  obi_rchk_checker i_instr_chk (
    .clk_i(clk_i), .arst_n(arst_n), .integrity_en(integrity_en), .resp_evt(instr_evt),
    .integrity_err(instr_integrity_err), .err_is_store()
  );

  obi_rchk_checker i_data_chk (
    .clk_i(clk_i), .arst_n(arst_n), .integrity_en(integrity_en), .resp_evt(data_evt),
    .integrity_err(data_integrity_err), .err_is_store(data_err_is_store)
  );

  integrity_alert_unit i_alert (
    .clk_i(clk_i), .arst_n(arst_n),
    .instr_parity_fault(instr_parity_fault), .data_parity_fault(data_parity_fault),
    .instr_err(instr_integrity_err), .data_err(data_integrity_err),
    .data_err_is_store(data_err_is_store),
    .alert_major(alert_major), .fault_code(fault_code)
  );

endmodule

/* tests/obi_integrity_tb.sv */
// Self-checking testbench for the OBI integrity unit
// Inputs change on the rising edge, outputs are sampled on the falling edge
// The memory model grants after 0 to 2 cycles and answers one cycle after the grant

`timescale 1ns/1ns
`include "obi_integrity_config.svh"

module obi_integrity_tb
  import obi_integrity_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int NUM_RANDOM     = 8;

  logic                     clk_i;
  logic                     arst_n;
  logic                     integrity_en;
  logic [1:0]               valid;
  logic [1:0]               gnt;
  logic [1:0]               gntpar;
  logic [1:0]               rvalid;
  logic [1:0]               rvalidpar;
  logic [1:0]               rsp_bad;
  logic [1:0]               exp_err_d;
  obi_req_t                 req_in [2];
  obi_resp_t                resp_in [2];
  obi_bus_out_t             instr_bus;
  obi_bus_out_t             data_bus;
  obi_bus_out_t             bus_q [2];
  logic                     instr_ready;
  logic                     data_ready;
  logic [1:0]               ready;
  logic                     instr_integrity_err;
  logic                     data_integrity_err;
  logic                     alert_major;
  logic [`FAULT_CODE_W-1:0] fault_code;
  integer                   seed;
  int                       errors;
  int                       checks;
  int                       cycles;
  obi_req_t                 r;

  always #10 clk_i = ~clk_i;

  obi_integrity_unit i_dut (
    .clk_i(clk_i), .arst_n(arst_n), .integrity_en(integrity_en),
    .instr_valid(valid[0]), .instr_req(req_in[0]), .instr_ready(instr_ready),
    .instr_bus(instr_bus), .instr_gnt(gnt[0]), .instr_gntpar(gntpar[0]),
    .instr_rvalid(rvalid[0]), .instr_rvalidpar(rvalidpar[0]), .instr_resp(resp_in[0]),
    .data_valid(valid[1]), .data_req(req_in[1]), .data_ready(data_ready),
    .data_bus(data_bus), .data_gnt(gnt[1]), .data_gntpar(gntpar[1]),
    .data_rvalid(rvalid[1]), .data_rvalidpar(rvalidpar[1]), .data_resp(resp_in[1]),
    .instr_integrity_err(instr_integrity_err), .data_integrity_err(data_integrity_err),
    .alert_major(alert_major), .fault_code(fault_code)
  );

  assign ready = {data_ready, instr_ready};

  always_comb begin
    bus_q[0] = instr_bus;
    bus_q[1] = data_bus;
  end

  // Odd parity bits make the field plus the bit odd, so they invert the XOR
  function automatic logic [`ACHK_W-1:0] ref_achk(input obi_req_t req);
    logic [`ACHK_W-1:0] a;
    int                 i;
    a = '0;
    for (i = 0; i < 4; i++) begin
      a[i]     = ^req.addr[8*i +: 8];
      a[9 + i] = ^req.wdata[8*i +: 8];
    end
    a[8] = ~req.dbg;
    a[5] = ~(^req.be ^ req.we);
    a[4] = ~(^req.prot ^ ^req.memtype);
    return a;
  endfunction

  function automatic logic [`RCHK_W-1:0] ref_rchk(input logic err, input logic [31:0] rdata);
    logic [`RCHK_W-1:0] c;
    int                 i;
    for (i = 0; i < 4; i++) begin
      c[i] = ^rdata[8*i +: 8];
    end
    c[4] = err;
    return c;
  endfunction

  function automatic string bus_name(input int b);
    return (b == 0) ? "instr" : "data";
  endfunction

  function automatic obi_req_t rand_req(input logic we);
    obi_req_t    req;
    logic [31:0] rnd;
    rnd         = $random(seed);
    req.addr    = $random(seed);
    req.wdata   = $random(seed);
    req.we      = we;
    req.be      = rnd[3:0];
    req.prot    = rnd[6:4];
    req.memtype = rnd[8:7];
    req.dbg     = rnd[9];
    return req;
  endfunction

  task automatic check_bus_out(input string name, input obi_bus_out_t got,
                               input obi_bus_out_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_code(input string name, input logic [`FAULT_CODE_W-1:0] got,
                            input logic [`FAULT_CODE_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
    end
  endtask

  task automatic idle_inputs();
    valid     <= '0;
    gnt       <= '0;
    gntpar    <= '1;
    rvalid    <= '0;
    rvalidpar <= '1;
    rsp_bad   <= '0;
    req_in[0] <= '0;
    req_in[1] <= '0;
  endtask

  // The alert is sticky, so every scenario starts from reset
  task automatic apply_reset();
    @(posedge clk_i);
    arst_n <= 1'b0;
    idle_inputs();
    repeat (5) @(posedge clk_i);
    arst_n <= 1'b1;
    @(posedge clk_i);
  endtask

  task automatic respond(input int b, input logic [`RCHK_W-1:0] flip, input logic exp_bad);
    obi_resp_t   rsp;
    logic [31:0] rnd;
    rnd          = $random(seed);
    rsp.rdata    = $random(seed);
    rsp.err      = rnd[0];
    rsp.rchk     = ref_rchk(rsp.err, rsp.rdata) ^ flip;
    resp_in[b]   <= rsp;
    rvalid[b]    <= 1'b1;
    rvalidpar[b] <= 1'b0;
    rsp_bad[b]   <= exp_bad;
    @(posedge clk_i);
    rvalid[b]    <= 1'b0;
    rvalidpar[b] <= 1'b1;
    rsp_bad[b]   <= 1'b0;
  endtask

  // One request with its grant and response; flip corrupts rchk bits
  task automatic access(input int b, input obi_req_t req, input logic [`RCHK_W-1:0] flip,
                        input logic gnt_bad, input logic en_req, input logic en_rsp);
    obi_req_t     sent;
    obi_bus_out_t exp;
    logic [31:0]  rnd;
    logic         mismatch;
    int           wait_cyc;
    rnd      = $random(seed);
    wait_cyc = int'(rnd[7:0] % 8'd3);
    sent     = req;
    if (b == 0) begin
      sent.be    = '1;
      sent.we    = 1'b0;
      sent.wdata = '0;
    end
    exp.req     = 1'b1;
    exp.reqpar  = 1'b0;
    exp.payload = sent;
    exp.achk    = ref_achk(sent);
    mismatch = (b == 1 && req.we) ? flip[`RCHK_STORE_BIT] : (flip != '0);
    integrity_en <= en_req;
    valid[b]     <= 1'b1;
    req_in[b]    <= req;
    repeat (wait_cyc) begin
      @(negedge clk_i);
      check_bus_out({bus_name(b), "_bus"}, bus_q[b], exp);
      @(posedge clk_i);
    end
    gnt[b]    <= 1'b1;
    gntpar[b] <= gnt_bad;
    @(negedge clk_i);
    check_bus_out({bus_name(b), "_bus"}, bus_q[b], exp);
    check_flag({bus_name(b), "_ready"}, ready[b], 1'b1);
    @(posedge clk_i);
    valid[b]     <= 1'b0;
    gnt[b]       <= 1'b0;
    gntpar[b]    <= 1'b1;
    integrity_en <= en_rsp;
    respond(b, flip, gnt_bad || (en_req && en_rsp && mismatch));
  endtask

  task automatic wait_and_check_alert(input logic exp_alert,
                                      input logic [`FAULT_CODE_W-1:0] exp_code);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("alert_major", alert_major, exp_alert);
    check_code("fault_code", fault_code, exp_code);
    @(posedge clk_i);
  endtask

  // Expected error pulse one cycle after each response
  always @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      exp_err_d <= '0;
    end else begin
      exp_err_d <= rvalid & rsp_bad;
    end
  end

  always @(negedge clk_i) begin
    if (arst_n === 1'b1) begin
      check_flag("instr_integrity_err", instr_integrity_err, exp_err_d[0]);
      check_flag("data_integrity_err", data_integrity_err, exp_err_d[1]);
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    seed         = 32'h638fa8f4;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    clk_i        = 1'b0;
    arst_n       = 1'b0;
    integrity_en = 1'b0;
    valid        = '0;
    gnt          = '0;
    gntpar       = '1;
    rvalid       = '0;
    rvalidpar    = '1;
    rsp_bad      = '0;
    req_in[0]    = '0;
    req_in[1]    = '0;
    resp_in[0]   = '0;
    resp_in[1]   = '0;

    apply_reset();
    @(negedge clk_i);
    check_flag("instr_bus.req", instr_bus.req, 1'b0);
    check_flag("data_bus.req", data_bus.req, 1'b0);
    check_flag("alert_major", alert_major, 1'b0);
    check_code("fault_code", fault_code, '0);
    @(posedge clk_i);

    // Clean traffic on both buses
    for (int i = 0; i < NUM_RANDOM; i++) begin
      access(0, rand_req(1'b0), '0, 1'b0, 1'b1, 1'b1);
      access(1, rand_req(1'b0), '0, 1'b0, 1'b1, 1'b1);
      access(1, rand_req(1'b1), '0, 1'b0, 1'b1, 1'b1);
    end
    wait_and_check_alert(1'b0, '0);

    // Load fault first, a later store fault keeps the load code
    apply_reset();
    access(1, rand_req(1'b0), 5'b00100, 1'b0, 1'b1, 1'b1);
    wait_and_check_alert(1'b1, `FAULT_LOAD_INTEGRITY);
    access(1, rand_req(1'b1), 5'b10000, 1'b0, 1'b1, 1'b1);
    wait_and_check_alert(1'b1, `FAULT_LOAD_INTEGRITY);

    apply_reset();
    access(1, rand_req(1'b1), 5'b10000, 1'b0, 1'b1, 1'b1);
    wait_and_check_alert(1'b1, `FAULT_STORE_INTEGRITY);

    // Stores ignore the data byte bits of rchk
    apply_reset();
    access(1, rand_req(1'b1), 5'b01111, 1'b0, 1'b1, 1'b1);
    wait_and_check_alert(1'b0, '0);

    apply_reset();
    access(0, rand_req(1'b0), 5'b00001, 1'b0, 1'b1, 1'b1);
    wait_and_check_alert(1'b1, '0);

    // Requests sent without integrity are not checked
    apply_reset();
    access(1, rand_req(1'b0), 5'b11111, 1'b0, 1'b0, 1'b1);
    access(0, rand_req(1'b0), 5'b00010, 1'b0, 1'b0, 1'b1);
    wait_and_check_alert(1'b0, '0);

    // Idle grant parity mismatch on the fetch bus
    apply_reset();
    gntpar[0] <= 1'b0;
    @(negedge clk_i);
    check_flag("alert_major", alert_major, 1'b0);
    @(posedge clk_i);
    gntpar[0] <= 1'b1;
    @(negedge clk_i);
    check_flag("alert_major", alert_major, 1'b1);
    @(posedge clk_i);

    apply_reset();
    rvalidpar[1] <= 1'b0;
    @(negedge clk_i);
    check_flag("alert_major", alert_major, 1'b0);
    @(posedge clk_i);
    rvalidpar[1] <= 1'b1;
    @(negedge clk_i);
    check_flag("alert_major", alert_major, 1'b1);
    @(posedge clk_i);

    // Grant parity fault flags the response of that request
    apply_reset();
    access(1, rand_req(1'b0), '0, 1'b1, 1'b1, 1'b1);
    wait_and_check_alert(1'b1, `FAULT_LOAD_INTEGRITY);
    access(0, rand_req(1'b0), '0, 1'b1, 1'b1, 1'b1);

    // Back-pressure with two outstanding loads
    apply_reset();
    r = rand_req(1'b0);
    integrity_en <= 1'b1;
    valid[1]     <= 1'b1;
    req_in[1]    <= r;
    gnt[1]       <= 1'b1;
    gntpar[1]    <= 1'b0;
    repeat (2) @(posedge clk_i);
    gnt[1]    <= 1'b0;
    gntpar[1] <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("data_ready", data_ready, 1'b0);
      check_flag("data_bus.req", data_bus.req, 1'b0);
      check_flag("data_bus.reqpar", data_bus.reqpar, 1'b1);
      @(posedge clk_i);
    end
    respond(1, '0, 1'b0);
    @(negedge clk_i);
    check_flag("data_ready", data_ready, 1'b1);
    check_flag("data_bus.req", data_bus.req, 1'b1);
    @(posedge clk_i);
    gnt[1]    <= 1'b1;
    gntpar[1] <= 1'b0;
    @(posedge clk_i);
    valid[1]  <= 1'b0;
    gnt[1]    <= 1'b0;
    gntpar[1] <= 1'b1;
    respond(1, '0, 1'b0);
    respond(1, '0, 1'b0);
    wait_and_check_alert(1'b0, '0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+design
design/obi_integrity_pkg.sv
design/obi_outstanding_fifo.sv
design/obi_bus_port.sv
design/obi_rchk_checker.sv
design/integrity_alert_unit.sv
design/obi_integrity_unit.sv
tests/obi_integrity_tb.sv
